// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

   // Field and datapath widths
   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;
   typedef logic [5:0]  opcodeT;
   typedef logic [5:0]  functT;
   typedef logic [3:0]  aluOpT;

   // Primary opcodes
   localparam opcodeT opRType = 6'h00;
   localparam opcodeT opJ     = 6'h02;
   localparam opcodeT opJal   = 6'h03;
   localparam opcodeT opBeq   = 6'h04;
   localparam opcodeT opBne   = 6'h05;
   localparam opcodeT opAddiu = 6'h09;
   localparam opcodeT opSlti  = 6'h0A;
   localparam opcodeT opAndi  = 6'h0C;
   localparam opcodeT opOri   = 6'h0D;
   localparam opcodeT opXori  = 6'h0E;
   localparam opcodeT opLui   = 6'h0F;
   localparam opcodeT opLw    = 6'h23;
   localparam opcodeT opSw    = 6'h2B;

   // R-type function codes
   localparam functT fnSll  = 6'h00;
   localparam functT fnSrl  = 6'h02;
   localparam functT fnSra  = 6'h03;
   localparam functT fnJr   = 6'h08;
   localparam functT fnAddu = 6'h21;
   localparam functT fnSubu = 6'h23;
   localparam functT fnAnd  = 6'h24;
   localparam functT fnOr   = 6'h25;
   localparam functT fnXor  = 6'h26;
   localparam functT fnSlt  = 6'h2A;
   localparam functT fnSltu = 6'h2B;

   // ALU operation selects
   localparam aluOpT aluAdd  = 4'd0;
   localparam aluOpT aluSub  = 4'd1;
   localparam aluOpT aluAnd  = 4'd2;
   localparam aluOpT aluOr   = 4'd3;
   localparam aluOpT aluXor  = 4'd4;
   localparam aluOpT aluSlt  = 4'd5;
   localparam aluOpT aluSltu = 4'd6;
   localparam aluOpT aluSll  = 4'd7;
   localparam aluOpT aluSrl  = 4'd8;
   localparam aluOpT aluSra  = 4'd9;
   localparam aluOpT aluLui  = 4'd10;

   // JAL destination
   localparam regAddrT linkReg = 5'd31;

endpackage

`default_nettype wire

// File: control/pipeControl.sv
`timescale 1ns/1ps
`default_nettype none

module pipeControl
   import mipsPkg::*;
(
   input  wire logic clk,
   input  wire logic reset,
   input  wordT      instrF,
   input  wire logic branchTakenE,
   output aluOpT     aluOp,
   output logic      aluSrcImm,
   output logic      shiftSel,
   output logic      zeroExt,
   output logic      jumpE,
   output logic      jrE,
   output logic      branchNeE,
   output logic      branchTaken,
   output logic      forwardA,
   output logic      forwardB,
   output logic      memWriteE,
   output logic      memToRegM,
   output logic      regWriteM,
   output logic      linkM,
   output regAddrT   writeRegM
);

   opcodeT  opcode;
   functT   funct;
   regAddrT rs, rt, rd;

   // F-stage decode results
   aluOpT   aluOpF;
   logic    aluSrcImmF, shiftSelF, jumpF, jrF, branchF, branchNeF;
   logic    memWriteF, memToRegF, regWriteF, linkF;
   regAddrT writeRegF;

   // E-stage copies not exported directly
   logic    branchE, memToRegE, regWriteE, linkE;
   regAddrT writeRegE, rsE, rtE;

   assign opcode = instrF[31:26];
   assign funct  = instrF[5:0];
   assign rs     = instrF[25:21];
   assign rt     = instrF[20:16];
   assign rd     = instrF[15:11];

   always_comb begin
      // Default is a no-op
      aluOpF     = aluAdd;
      aluSrcImmF = 1'b1;
      shiftSelF  = 1'b0;
      zeroExt    = 1'b0;
      jumpF      = 1'b0;
      jrF        = 1'b0;
      branchF    = 1'b0;
      branchNeF  = 1'b0;
      memWriteF  = 1'b0;
      memToRegF  = 1'b0;
      regWriteF  = 1'b0;
      linkF      = 1'b0;
      writeRegF  = rt;
      case (opcode)
         opRType: begin
            aluSrcImmF = 1'b0;
            writeRegF  = rd;
            regWriteF  = 1'b1;
            case (funct)
               fnAddu: aluOpF = aluAdd;
               fnSubu: aluOpF = aluSub;
               fnAnd:  aluOpF = aluAnd;
               fnOr:   aluOpF = aluOr;
               fnXor:  aluOpF = aluXor;
               fnSlt:  aluOpF = aluSlt;
               fnSltu: aluOpF = aluSltu;
               fnSll: begin
                  aluOpF    = aluSll;
                  shiftSelF = 1'b1;
               end
               fnSrl: begin
                  aluOpF    = aluSrl;
                  shiftSelF = 1'b1;
               end
               fnSra: begin
                  aluOpF    = aluSra;
                  shiftSelF = 1'b1;
               end
               fnJr: begin
                  // Register jump, nothing written
                  jrF       = 1'b1;
                  regWriteF = 1'b0;
               end
               default: regWriteF = 1'b0;
            endcase
         end
         opAddiu: regWriteF = 1'b1;
         opSlti: begin
            aluOpF    = aluSlt;
            regWriteF = 1'b1;
         end
         opAndi: begin
            aluOpF    = aluAnd;
            zeroExt   = 1'b1;
            regWriteF = 1'b1;
         end
         opOri: begin
            aluOpF    = aluOr;
            zeroExt   = 1'b1;
            regWriteF = 1'b1;
         end
         opXori: begin
            aluOpF    = aluXor;
            zeroExt   = 1'b1;
            regWriteF = 1'b1;
         end
         opLui: begin
            aluOpF    = aluLui;
            regWriteF = 1'b1;
         end
         opLw: begin
            memToRegF = 1'b1;
            regWriteF = 1'b1;
         end
         opSw: memWriteF = 1'b1;
         opBeq: begin
            aluSrcImmF = 1'b0;
            branchF    = 1'b1;
         end
         opBne: begin
            aluSrcImmF = 1'b0;
            branchF    = 1'b1;
            branchNeF  = 1'b1;
         end
         opJ: jumpF = 1'b1;
         opJal: begin
            // Link address lands in r31
            jumpF     = 1'b1;
            linkF     = 1'b1;
            regWriteF = 1'b1;
            writeRegF = linkReg;
         end
         default: aluSrcImmF = 1'b1;
      endcase
   end

   // F to E control register
   always_ff @(posedge clk) begin
      if (reset) begin
         aluOp     <= aluAdd;
         aluSrcImm <= 1'b0;
         shiftSel  <= 1'b0;
         jumpE     <= 1'b0;
         jrE       <= 1'b0;
         branchE   <= 1'b0;
         branchNeE <= 1'b0;
         memWriteE <= 1'b0;
         memToRegE <= 1'b0;
         regWriteE <= 1'b0;
         linkE     <= 1'b0;
         writeRegE <= '0;
         rsE       <= '0;
         rtE       <= '0;
      end else begin
         aluOp     <= aluOpF;
         aluSrcImm <= aluSrcImmF;
         shiftSel  <= shiftSelF;
         jumpE     <= jumpF;
         jrE       <= jrF;
         branchE   <= branchF;
         branchNeE <= branchNeF;
         memWriteE <= memWriteF;
         memToRegE <= memToRegF;
         regWriteE <= regWriteF;
         linkE     <= linkF;
         writeRegE <= writeRegF;
         rsE       <= rs;
         rtE       <= rt;
      end
   end

   // E to M control register
   always_ff @(posedge clk) begin
      if (reset) begin
         memToRegM <= 1'b0;
         regWriteM <= 1'b0;
         linkM     <= 1'b0;
         writeRegM <= '0;
      end else begin
         memToRegM <= memToRegE;
         regWriteM <= regWriteE;
         linkM     <= linkE;
         writeRegM <= writeRegE;
      end
   end

   // Compare result only counts for a real branch in E
   assign branchTaken = branchE && branchTakenE;

   // M to E bypass, r0 never forwarded
   assign forwardA = regWriteM && (writeRegM != '0) && (rsE == writeRegM);
   assign forwardB = regWriteM && (writeRegM != '0) && (rtE == writeRegM);

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
   import mipsPkg::*;
#(
   parameter int imemWords = 256
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         imemLoadEn,
   input  wire logic [$clog2(imemWords)-1:0] imemLoadAddr,
   input  wordT                              imemLoadData,
   input  wire logic                         branchTaken,
   input  wire logic                         jumpE,
   input  wire logic                         jrE,
   input  wordT                              targetE,
   input  wordT                              branchOffsetE,
   input  wordT                              jrValueE,
   output wordT                              instrF,
   output wordT                              pcF
);

   localparam int imemAddrBits = $clog2(imemWords);

   wordT imem [imemWords];
   wordT nextPc;

   // Load port, used while the core sits in reset
   always_ff @(posedge clk) begin
      if (imemLoadEn) imem[imemLoadAddr] <= imemLoadData;
   end

   assign instrF = imem[pcF[imemAddrBits+1:2]];

   // pcF already holds the delay slot when the E instruction redirects
   always_comb begin
      if (branchTaken) nextPc = pcF + branchOffsetE;
      else if (jumpE) nextPc = {pcF[31:28], targetE[25:0], 2'b00};
      else if (jrE) nextPc = jrValueE;
      else nextPc = pcF + 32'd4;
   end

   always_ff @(posedge clk) begin
      if (reset) pcF <= '0;
      else pcF <= nextPc;
   end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
   import mipsPkg::*;
(
   input  wire logic clk,
   input  regAddrT   readAddrA,
   input  regAddrT   readAddrB,
   input  wire logic writeEn,
   input  regAddrT   writeAddr,
   input  wordT      writeData,
   output wordT      readDataA,
   output wordT      readDataB
);

   wordT regs [32];

   // Writer already excludes r0
   always_ff @(posedge clk) begin
      if (writeEn) regs[writeAddr] <= writeData;
   end

   // Write-through gives the M to F bypass
   always_comb begin
      if (readAddrA == '0) readDataA = '0;
      else if (writeEn && writeAddr == readAddrA) readDataA = writeData;
      else readDataA = regs[readAddrA];
      if (readAddrB == '0) readDataB = '0;
      else if (writeEn && writeAddr == readAddrB) readDataB = writeData;
      else readDataB = regs[readAddrB];
   end

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit
   import mipsPkg::*;
(
   input  wire logic clk,
   input  wire logic reset,
   input  wordT      instrF,
   input  wordT      pcF,
   input  wordT      readDataA,
   input  wordT      readDataB,
   input  wire logic zeroExt,
   input  aluOpT     aluOp,
   input  wire logic aluSrcImm,
   input  wire logic shiftSel,
   input  wire logic forwardA,
   input  wire logic forwardB,
   input  wire logic branchNeE,
   input  wordT      writeBackM,
   output wordT      aluOutE,
   output wordT      storeDataE,
   output wordT      branchOffsetE,
   output wordT      targetE,
   output wordT      jrValueE,
   output wordT      pcE,
   output logic      branchTakenE
);

   wordT       opAE, opBE, immE, immF;
   wordT       fwdA, fwdB, aluA, aluB;
   logic [4:0] shamtE;

   // Extension picked by the F-stage decode
   assign immF = zeroExt ? {16'b0, instrF[15:0]} : {{16{instrF[15]}}, instrF[15:0]};

   always_ff @(posedge clk) begin
      if (reset) begin
         opAE          <= '0;
         opBE          <= '0;
         immE          <= '0;
         shamtE        <= '0;
         pcE           <= '0;
         targetE       <= '0;
         branchOffsetE <= '0;
      end else begin
         opAE          <= readDataA;
         opBE          <= readDataB;
         immE          <= immF;
         shamtE        <= instrF[10:6];
         pcE           <= pcF;
         targetE       <= {6'b0, instrF[25:0]};
         // Word offset, always sign extended
         branchOffsetE <= {{14{instrF[15]}}, instrF[15:0], 2'b00};
      end
   end

   // Bypass from the instruction in M
   assign fwdA = forwardA ? writeBackM : opAE;
   assign fwdB = forwardB ? writeBackM : opBE;

   assign aluA = shiftSel ? {27'b0, shamtE} : fwdA;
   assign aluB = aluSrcImm ? immE : fwdB;

   always_comb begin
      case (aluOp)
         aluAdd:  aluOutE = aluA + aluB;
         aluSub:  aluOutE = aluA - aluB;
         aluAnd:  aluOutE = aluA & aluB;
         aluOr:   aluOutE = aluA | aluB;
         aluXor:  aluOutE = aluA ^ aluB;
         aluSlt:  aluOutE = {31'b0, $signed(aluA) < $signed(aluB)};
         aluSltu: aluOutE = {31'b0, aluA < aluB};
         aluSll:  aluOutE = aluB << aluA[4:0];
         aluSrl:  aluOutE = aluB >> aluA[4:0];
         aluSra:  aluOutE = $signed(aluB) >>> aluA[4:0];
         aluLui:  aluOutE = {aluB[15:0], 16'b0};
         default: aluOutE = '0;
      endcase
   end

   // Raw condition, gated by the branch flag in control
   assign branchTakenE = branchNeE ? (fwdA != fwdB) : (fwdA == fwdB);
   assign storeDataE   = fwdB;
   assign jrValueE     = fwdA;

endmodule

`default_nettype wire

// File: logic/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage
   import mipsPkg::*;
#(
   parameter int dmemWords = 256
) (
   input  wire logic clk,
   input  wire logic reset,
   input  wordT      aluOutE,
   input  wordT      storeDataE,
   input  wordT      pcE,
   input  wire logic memWriteE,
   input  wire logic memToRegM,
   input  wire logic linkM,
   input  wire logic regWriteM,
   input  regAddrT   writeRegM,
   output wordT      writeBackM,
   output wordT      regWriteData,
   output logic      regWriteEn,
   output regAddrT   regWriteAddr
);

   localparam int dmemAddrBits = $clog2(dmemWords);

   wordT dmem [dmemWords];
   wordT aluOutM, pcM, loadDataM;

   // Store lands on the edge that closes E
   always_ff @(posedge clk) begin
      if (memWriteE) dmem[aluOutE[dmemAddrBits+1:2]] <= storeDataE;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         aluOutM <= '0;
         pcM     <= '0;
      end else begin
         aluOutM <= aluOutE;
         pcM     <= pcE;
      end
   end

   // Asynchronous read, so a dependent op needs no stall
   assign loadDataM = dmem[aluOutM[dmemAddrBits+1:2]];

   // JAL link skips the delay slot
   assign writeBackM = linkM ? pcM + 32'd8 : (memToRegM ? loadDataM : aluOutM);

   assign regWriteEn   = regWriteM && (writeRegM != '0);
   assign regWriteAddr = writeRegM;
   // Zero outside a write keeps the retire port quiet
   assign regWriteData = regWriteEn ? writeBackM : '0;

endmodule

`default_nettype wire

// File: logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
   import mipsPkg::*;
#(
   parameter int imemWords = 256,
   parameter int dmemWords = 256
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         imemLoadEn,
   input  wire logic [$clog2(imemWords)-1:0] imemLoadAddr,
   input  wordT                              imemLoadData,
   output logic                              retireValid,
   output regAddrT                           retireReg,
   output wordT                              retireData
);

   // Fetch side
   wordT    instrF, pcF, readDataA, readDataB;

   // Controls from pipeControl
   aluOpT   aluOp;
   logic    aluSrcImm, shiftSel, zeroExt, jumpE, jrE, branchNeE, branchTaken;
   logic    forwardA, forwardB, memWriteE, memToRegM, regWriteM, linkM;
   regAddrT writeRegM;

   // E-stage values
   wordT    aluOutE, storeDataE, branchOffsetE, targetE, jrValueE, pcE;
   logic    branchTakenE;

   // Bypass value from M
   wordT    writeBackM;

   pipeControl control (
      .clk(clk), .reset(reset), .instrF(instrF), .branchTakenE(branchTakenE),
      .aluOp(aluOp), .aluSrcImm(aluSrcImm), .shiftSel(shiftSel), .zeroExt(zeroExt),
      .jumpE(jumpE), .jrE(jrE), .branchNeE(branchNeE), .branchTaken(branchTaken),
      .forwardA(forwardA), .forwardB(forwardB), .memWriteE(memWriteE),
      .memToRegM(memToRegM), .regWriteM(regWriteM), .linkM(linkM), .writeRegM(writeRegM)
   );

   fetchUnit #(.imemWords(imemWords)) fetch (
      .clk(clk), .reset(reset), .imemLoadEn(imemLoadEn), .imemLoadAddr(imemLoadAddr),
      .imemLoadData(imemLoadData), .branchTaken(branchTaken), .jumpE(jumpE), .jrE(jrE),
      .targetE(targetE), .branchOffsetE(branchOffsetE), .jrValueE(jrValueE),
      .instrF(instrF), .pcF(pcF)
   );

   // Retire port is the register write port
   regFile regs (
      .clk(clk), .readAddrA(instrF[25:21]), .readAddrB(instrF[20:16]),
      .writeEn(retireValid), .writeAddr(retireReg), .writeData(retireData),
      .readDataA(readDataA), .readDataB(readDataB)
   );

   executeUnit execute (
      .clk(clk), .reset(reset), .instrF(instrF), .pcF(pcF), .readDataA(readDataA),
      .readDataB(readDataB), .zeroExt(zeroExt), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
      .shiftSel(shiftSel), .forwardA(forwardA), .forwardB(forwardB),
      .branchNeE(branchNeE), .writeBackM(writeBackM), .aluOutE(aluOutE),
      .storeDataE(storeDataE), .branchOffsetE(branchOffsetE), .targetE(targetE),
      .jrValueE(jrValueE), .pcE(pcE), .branchTakenE(branchTakenE)
   );

   memStage #(.dmemWords(dmemWords)) mem (
      .clk(clk), .reset(reset), .aluOutE(aluOutE), .storeDataE(storeDataE), .pcE(pcE),
      .memWriteE(memWriteE), .memToRegM(memToRegM), .linkM(linkM),
      .regWriteM(regWriteM), .writeRegM(writeRegM), .writeBackM(writeBackM),
      .regWriteData(retireData), .regWriteEn(retireValid), .regWriteAddr(retireReg)
   );

endmodule

`default_nettype wire

// File: verif/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
   parameter int periodNs    = 40,
   parameter int resetCycles = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   // Release a little after the edge, like every other driven input
   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      #2;
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// File: verif/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb
   import mipsPkg::*;
();

   localparam int imemWords     = 256;
   localparam int dmemWords     = 256;
   localparam int addrBits      = $clog2(imemWords);
   localparam int maxRows       = 64;
   localparam int driveDelay    = 2;
   localparam int retireTimeout = 16;
   localparam int resetTimeout  = 200;
   localparam int quietCycles   = 12;

   logic                clk, genReset, coreReset, loadBusy;
   logic                imemLoadEn;
   logic [addrBits-1:0] imemLoadAddr;
   wordT                imemLoadData;
   logic                retireValid;
   regAddrT             retireReg;
   wordT                retireData;

   // Program table, one row per instruction word in address order
   wordT    instrs   [maxRows];
   logic    expWrite [maxRows];
   regAddrT expReg   [maxRows];
   wordT    expValue [maxRows];
   int      rowCount;
   int      passCount;
   int      failCount;

   // Core stays in reset until the whole program is loaded
   assign coreReset = genReset | loadBusy;

   clockGen #(.periodNs(40), .resetCycles(8)) clocks (.clk(clk), .reset(genReset));

   mipsCore #(.imemWords(imemWords), .dmemWords(dmemWords)) DUT (
      .clk(clk), .reset(coreReset), .imemLoadEn(imemLoadEn), .imemLoadAddr(imemLoadAddr),
      .imemLoadData(imemLoadData), .retireValid(retireValid), .retireReg(retireReg),
      .retireData(retireData)
   );

   // Instruction formats
   function automatic wordT rFormat(functT fn, regAddrT rs, regAddrT rt, regAddrT rd,
                                    logic [4:0] shamt);
      return {opRType, rs, rt, rd, shamt, fn};
   endfunction

   function automatic wordT iFormat(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic wordT jFormat(opcodeT op, logic [25:0] target);
      return {op, target};
   endfunction

   task automatic addRow(wordT instr, logic write, regAddrT rd, wordT value);
      instrs[rowCount]   = instr;
      expWrite[rowCount] = write;
      expReg[rowCount]   = rd;
      expValue[rowCount] = value;
      rowCount++;
   endtask

   task automatic buildProgram;
      // ALU and immediates, back to back dependencies
      addRow(iFormat(opAddiu, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'h0000_0005);
      addRow(iFormat(opAddiu, 5'd0, 5'd2, 16'hFFFD), 1'b1, 5'd2, 32'hFFFF_FFFD);
      addRow(rFormat(fnAddu, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd3, 32'h0000_0002);
      addRow(rFormat(fnSubu, 5'd3, 5'd1, 5'd4, 5'd0), 1'b1, 5'd4, 32'hFFFF_FFFD);
      addRow(rFormat(fnSlt, 5'd4, 5'd1, 5'd5, 5'd0), 1'b1, 5'd5, 32'h0000_0001);
      addRow(rFormat(fnSltu, 5'd4, 5'd1, 5'd6, 5'd0), 1'b1, 5'd6, 32'h0000_0000);
      addRow(iFormat(opAndi, 5'd2, 5'd7, 16'hFF0F), 1'b1, 5'd7, 32'h0000_FF0D);
      addRow(iFormat(opOri, 5'd7, 5'd8, 16'h00F0), 1'b1, 5'd8, 32'h0000_FFFD);
      addRow(iFormat(opXori, 5'd8, 5'd9, 16'h8001), 1'b1, 5'd9, 32'h0000_7FFC);
      addRow(iFormat(opSlti, 5'd2, 5'd10, 16'hFFFF), 1'b1, 5'd10, 32'h0000_0001);
      addRow(iFormat(opLui, 5'd0, 5'd11, 16'h8765), 1'b1, 5'd11, 32'h8765_0000);
      addRow(rFormat(fnOr, 5'd11, 5'd9, 5'd12, 5'd0), 1'b1, 5'd12, 32'h8765_7FFC);
      addRow(rFormat(fnSll, 5'd0, 5'd1, 5'd13, 5'd4), 1'b1, 5'd13, 32'h0000_0050);
      addRow(rFormat(fnSrl, 5'd0, 5'd11, 5'd14, 5'd8), 1'b1, 5'd14, 32'h0087_6500);
      addRow(rFormat(fnSra, 5'd0, 5'd11, 5'd15, 5'd8), 1'b1, 5'd15, 32'hFF87_6500);
      addRow(rFormat(fnAnd, 5'd12, 5'd15, 5'd16, 5'd0), 1'b1, 5'd16, 32'h8705_6500);
      addRow(rFormat(fnXor, 5'd16, 5'd13, 5'd17, 5'd0), 1'b1, 5'd17, 32'h8705_6550);
      // Store, load, then use the load at once
      addRow(iFormat(opAddiu, 5'd0, 5'd18, 16'h0040), 1'b1, 5'd18, 32'h0000_0040);
      addRow(iFormat(opSw, 5'd18, 5'd17, 16'd4), 1'b0, 5'd0, 32'h0);
      addRow(iFormat(opLw, 5'd18, 5'd19, 16'd4), 1'b1, 5'd19, 32'h8705_6550);
      addRow(rFormat(fnAddu, 5'd19, 5'd1, 5'd20, 5'd0), 1'b1, 5'd20, 32'h8705_6555);
      // Taken BEQ over two rows
      addRow(iFormat(opBeq, 5'd19, 5'd17, 16'd3), 1'b0, 5'd0, 32'h0);
      addRow(iFormat(opAddiu, 5'd0, 5'd21, 16'h0050), 1'b1, 5'd21, 32'h0000_0050);
      addRow(iFormat(opAddiu, 5'd0, 5'd25, 16'h0BAD), 1'b0, 5'd0, 32'h0);
      addRow(iFormat(opAddiu, 5'd0, 5'd25, 16'h0BAD), 1'b0, 5'd0, 32'h0);
      // Untaken BNE, operands equal
      addRow(iFormat(opBne, 5'd21, 5'd13, 16'd2), 1'b0, 5'd0, 32'h0);
      addRow(iFormat(opAddiu, 5'd21, 5'd22, 16'd1), 1'b1, 5'd22, 32'h0000_0051);
      addRow(iFormat(opAddiu, 5'd22, 5'd23, 16'd1), 1'b1, 5'd23, 32'h0000_0052);
      // J over one row
      addRow(jFormat(opJ, 26'd31), 1'b0, 5'd0, 32'h0);
      addRow(iFormat(opAddiu, 5'd0, 5'd24, 16'h0029), 1'b1, 5'd24, 32'h0000_0029);
      addRow(iFormat(opAddiu, 5'd0, 5'd25, 16'h0BAD), 1'b0, 5'd0, 32'h0);
      // JAL at 0x7C links 0x84, subroutine at word 35
      addRow(jFormat(opJal, 26'd35), 1'b1, 5'd31, 32'h0000_0084);
      addRow(iFormat(opAddiu, 5'd31, 5'd26, 16'd4), 1'b1, 5'd26, 32'h0000_0088);
      addRow(jFormat(opJ, 26'd37), 1'b0, 5'd0, 32'h0);
      addRow(rFormat(fnAddu, 5'd0, 5'd26, 5'd27, 5'd0), 1'b1, 5'd27, 32'h0000_0088);
      addRow(rFormat(fnJr, 5'd31, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0);
      // Write to r0 in the JR delay slot, must stay silent
      addRow(iFormat(opAddiu, 5'd26, 5'd0, 16'd7), 1'b0, 5'd0, 32'h0);
      addRow(rFormat(fnAddu, 5'd31, 5'd0, 5'd28, 5'd0), 1'b1, 5'd28, 32'h0000_0084);
      // Parking loop
      addRow(jFormat(opJ, 26'd38), 1'b0, 5'd0, 32'h0);
      addRow(32'h0000_0000, 1'b0, 5'd0, 32'h0);
   endtask

   // One word per cycle through the load port
   task automatic loadProgram;
      int row;
      for (row = 0; row < rowCount; row++) begin
         @(posedge clk);
         #driveDelay;
         imemLoadEn   = 1'b1;
         imemLoadAddr = addrBits'(row);
         imemLoadData = instrs[row];
      end
      @(posedge clk);
      #driveDelay;
      imemLoadEn = 1'b0;
      loadBusy   = 1'b0;
   endtask

   // Retire port must stay quiet while reset is high
   task automatic watchReset;
      int cycles;
      int spurious;
      cycles   = 0;
      spurious = 0;
      do begin
         @(negedge clk);
         if (coreReset && retireValid !== 1'b0) spurious++;
         cycles++;
      end while (coreReset && cycles < resetTimeout);
      if (coreReset) begin
         failCount++;
         $display("Timeout: reset was still held after %0d cycles", cycles);
      end else begin
         assert (spurious == 0) begin
            passCount++;
            $display("reset: retireValid stayed low for %0d cycles", cycles);
         end else begin
            failCount++;
            $display("** Error at %0t: retireValid high in %0d reset cycles", $time, spurious);
         end
      end
   endtask

   task automatic waitRetire(output logic seen, output int cycles);
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < retireTimeout) begin
         @(negedge clk);
         cycles++;
         if (retireValid === 1'b1) seen = 1'b1;
      end
   endtask

   task automatic checkRetires;
      int   row;
      int   cycles;
      logic seen;
      logic first;
      first = 1'b1;
      for (row = 0; row < rowCount; row++) begin
         if (!expWrite[row]) continue;
         waitRetire(seen, cycles);
         if (!seen) begin
            failCount++;
            $display("Timeout: row %0d did not retire within %0d cycles", row, retireTimeout);
            return;
         end
         // Address 0 sits in F in cycle 1, so it retires in cycle 3
         if (first) begin
            assert (cycles == 2) begin
               passCount++;
               $display("first retire in cycle 3 after reset");
            end else begin
               failCount++;
               $display("** Error at %0t: first retire in cycle %0d, expected 3", $time,
                        cycles + 1);
            end
            first = 1'b0;
         end
         assert (retireReg == expReg[row] && retireData == expValue[row]) begin
            passCount++;
            $display("row %0d: r%0d = %08h", row, retireReg, retireData);
         end else begin
            failCount++;
            $display("** Error at %0t: row %0d expected r%0d = %08h, got r%0d = %08h", $time,
                     row, expReg[row], expValue[row], retireReg, retireData);
         end
      end
   endtask

   // Parking loop writes nothing
   task automatic checkQuiet;
      int cycles;
      int extra;
      extra = 0;
      for (cycles = 0; cycles < quietCycles; cycles++) begin
         @(negedge clk);
         if (retireValid === 1'b1) extra++;
      end
      assert (extra == 0) begin
         passCount++;
         $display("no extra retires in %0d cycles after the program", quietCycles);
      end else begin
         failCount++;
         $display("** Error at %0t: %0d unexpected retires after the program", $time, extra);
      end
   endtask

   initial begin
      imemLoadEn   = 1'b0;
      imemLoadAddr = '0;
      imemLoadData = '0;
      loadBusy     = 1'b1;
      rowCount     = 0;
      passCount    = 0;
      failCount    = 0;
      buildProgram();
      fork
         loadProgram();
         watchReset();
      join
      checkRetires();
      checkQuiet();
      $display("checks passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
common/mipsPkg.sv
control/pipeControl.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/memStage.sv
logic/mipsCore.sv
verif/clockGen.sv
verif/coreTb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = coreTb
RTL_TOP    = mipsCore
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
